//--- src/bus_pkg.sv
package bus_pkg;

    // read only instruction side
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } ibus_req_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] data;
    } ibus_resp_t;

    // strobe of zero marks a data read
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [3:0]  strobe;
        logic [31:0] data;
    } dbus_req_t;

    // read data only meaningful in the transfer cycle
    typedef struct packed {
        logic        ready;
        logic [31:0] data;
    } dbus_resp_t;

endpackage

//--- src/core_pkg.sv
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // first fetch address and architectural register count
    localparam word_t RESET_PC = 32'hbfc0_0000;
    localparam int    NUM_REGS = 32;

    // alu operations
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        SLT,
        LUI,
        PASS_B
    } op_e;

    // controller states for one pass per instruction
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } state_e;

    typedef struct packed {
        op_e       op;
        reg_addr_t ra1;
        reg_addr_t ra2;
        reg_addr_t rdst;
        // already extended by the decoder
        word_t     imm;
        logic      use_imm;
        logic      regwrite;
        logic      memread;
        logic      memwrite;
        logic      branch;
        logic      branch_ne;
        // low for encodings outside the supported subset
        logic      valid;
    } decoded_t;

endpackage

//--- src/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl (
    input  logic                clk,
    input  logic                resetn,
    input  core_pkg::decoded_t  dec,
    input  logic                ifetch_done,
    input  logic                dmem_done,
    input  logic                taken,
    output core_pkg::state_e    state,
    output logic                instr_load,
    output logic                pc_inc,
    output logic                pc_load,
    output logic                rf_write,
    output logic                fetch_req,
    output logic                mem_req,
    output logic                wb_sel
);

    core_pkg::state_e state_next;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= core_pkg::FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            core_pkg::FETCH: begin
                if (ifetch_done) begin
                    state_next = core_pkg::DECODE;
                end
            end
            core_pkg::DECODE: begin
                state_next = core_pkg::EXECUTE;
            end
            core_pkg::EXECUTE: begin
                // unsupported encodings fall straight through as a no-op
                if (!dec.valid) begin
                    state_next = core_pkg::FETCH;
                end else if (dec.memread || dec.memwrite) begin
                    state_next = core_pkg::MEMORY;
                end else if (dec.regwrite) begin
                    state_next = core_pkg::WRITEBACK;
                end else begin
                    state_next = core_pkg::FETCH;
                end
            end
            core_pkg::MEMORY: begin
                // wait here for as long as the data bus holds off ready
                if (dmem_done) begin
                    state_next = core_pkg::WRITEBACK;
                end
            end
            default: begin
                state_next = core_pkg::FETCH;
            end
        endcase
    end

    // no fetch request while the core is held in reset
    assign fetch_req  = (state == core_pkg::FETCH) && !resetn;
    assign mem_req    = (state == core_pkg::MEMORY);

    // pc moves to pc + 4 as soon as the instruction word arrives
    assign instr_load = (state == core_pkg::FETCH) && ifetch_done;
    assign pc_inc     = instr_load;

    // taken branch overrides the increment already applied
    assign pc_load    = (state == core_pkg::EXECUTE) && dec.valid && dec.branch && taken;

    // stores also pass through writeback but never write a register
    assign rf_write   = (state == core_pkg::WRITEBACK) && dec.valid && dec.regwrite;
    assign wb_sel     = dec.memread;

endmodule

//--- src/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
    input  logic            clk,
    input  logic            resetn,
    input  logic            inc,
    input  logic            load,
    input  core_pkg::word_t target,
    output core_pkg::word_t pc
);

    core_pkg::word_t pc_next;

    // branch load wins over the sequential step
    always_comb begin
        pc_next = pc;
        if (load) begin
            pc_next = target;
        end else if (inc) begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            pc <= core_pkg::RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

//--- src/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  core_pkg::word_t    instr,
    output core_pkg::decoded_t dec
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        dec      = '0;
        dec.op   = core_pkg::PASS_B;
        dec.ra1  = instr[25:21];
        dec.ra2  = instr[20:16];
        // i-type writes rt unless overridden below
        dec.rdst = instr[20:16];
        dec.imm  = {{16{instr[15]}}, instr[15:0]};
        case (opcode)
            6'h00: begin
                dec.rdst     = instr[15:11];
                dec.regwrite = 1'b1;
                dec.valid    = 1'b1;
                case (funct)
                    6'h21: dec.op = core_pkg::ADD;
                    6'h23: dec.op = core_pkg::SUB;
                    6'h24: dec.op = core_pkg::AND;
                    6'h25: dec.op = core_pkg::OR;
                    6'h2a: dec.op = core_pkg::SLT;
                    default: begin
                        dec.regwrite = 1'b0;
                        dec.valid    = 1'b0;
                    end
                endcase
            end
            6'h09: begin
                dec.op       = core_pkg::ADD;
                dec.use_imm  = 1'b1;
                dec.regwrite = 1'b1;
                dec.valid    = 1'b1;
            end
            6'h0f: begin
                // immediate lands in the upper half
                dec.op       = core_pkg::LUI;
                dec.imm      = {instr[15:0], 16'h0000};
                dec.use_imm  = 1'b1;
                dec.regwrite = 1'b1;
                dec.valid    = 1'b1;
            end
            6'h23: begin
                dec.op       = core_pkg::ADD;
                dec.use_imm  = 1'b1;
                dec.regwrite = 1'b1;
                dec.memread  = 1'b1;
                dec.valid    = 1'b1;
            end
            6'h2b: begin
                dec.op       = core_pkg::ADD;
                dec.use_imm  = 1'b1;
                dec.memwrite = 1'b1;
                dec.valid    = 1'b1;
            end
            6'h04, 6'h05: begin
                dec.branch    = 1'b1;
                dec.branch_ne = opcode[0];
                dec.valid     = 1'b1;
            end
            default: begin
                dec.valid = 1'b0;
            end
        endcase
    end

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
    input  core_pkg::decoded_t dec,
    input  core_pkg::word_t    a,
    input  core_pkg::word_t    b,
    output core_pkg::word_t    result,
    output logic               taken
);

    core_pkg::word_t b_op;

    assign b_op = dec.use_imm ? dec.imm : b;

    always_comb begin
        case (dec.op)
            core_pkg::ADD: result = a + b_op;
            core_pkg::SUB: result = a - b_op;
            core_pkg::AND: result = a & b_op;
            core_pkg::OR:  result = a | b_op;
            core_pkg::SLT: result = {31'd0, $signed(a) < $signed(b_op)};
            // low half forced clear
            core_pkg::LUI: result = {b_op[31:16], 16'h0000};
            default:       result = b_op;
        endcase
    end

    // beq and bne compare the two registers, never the immediate
    assign taken = dec.branch && ((a == b) != dec.branch_ne);

endmodule

//--- src/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  logic                resetn,
    input  core_pkg::reg_addr_t ra1,
    input  core_pkg::reg_addr_t ra2,
    input  logic                we,
    input  core_pkg::reg_addr_t wa,
    input  core_pkg::word_t     wd,
    output core_pkg::word_t     rd1,
    output core_pkg::word_t     rd2
);

    core_pkg::word_t regs [core_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            // r0 is never written so it keeps its reset value
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

//--- src/mycore.sv
`timescale 1ns/1ps

module mycore (
    input  logic                clk,
    input  logic                resetn,
    output bus_pkg::ibus_req_t  ireq,
    input  bus_pkg::ibus_resp_t iresp,
    output bus_pkg::dbus_req_t  dreq,
    input  bus_pkg::dbus_resp_t dresp
);

    core_pkg::state_e   state;
    core_pkg::decoded_t dec_d;
    core_pkg::decoded_t dec_q;
    core_pkg::word_t    pc;
    core_pkg::word_t    target;
    core_pkg::word_t    instr_q;
    core_pkg::word_t    rd1;
    core_pkg::word_t    rd2;
    core_pkg::word_t    alu_result;
    core_pkg::word_t    result_q;
    core_pkg::word_t    load_q;
    core_pkg::word_t    wd;
    logic               instr_load;
    logic               pc_inc;
    logic               pc_load;
    logic               rf_write;
    logic               fetch_req;
    logic               mem_req;
    logic               wb_sel;
    logic               taken;
    logic               ifetch_done;
    logic               dmem_done;

    assign ifetch_done = ireq.valid && iresp.ready;
    assign dmem_done   = dreq.valid && dresp.ready;

    core_ctrl core_ctrl_i (
        .clk, .resetn, .dec(dec_q), .ifetch_done, .dmem_done, .taken,
        .state, .instr_load, .pc_inc, .pc_load, .rf_write, .fetch_req, .mem_req, .wb_sel
    );

    // pc already holds pc + 4 once the instruction has been fetched
    assign target = pc + {dec_q.imm[29:0], 2'b00};

    pc_unit pc_unit_i (.clk, .resetn, .inc(pc_inc), .load(pc_load), .target, .pc);

    decoder decoder_i (.instr(instr_q), .dec(dec_d));

    regfile regfile_i (
        .clk, .resetn, .ra1(dec_q.ra1), .ra2(dec_q.ra2),
        .we(rf_write), .wa(dec_q.rdst), .wd, .rd1, .rd2
    );

    alu alu_i (.dec(dec_q), .a(rd1), .b(rd2), .result(alu_result), .taken);

    always_ff @(posedge clk) begin
        if (resetn) begin
            dec_q <= '0;
        end else if (state == core_pkg::DECODE) begin
            dec_q <= dec_d;
        end
    end

    // holding registers for the instruction word, alu result and load data
    always_ff @(posedge clk) begin
        if (instr_load) begin
            instr_q <= iresp.data;
        end
        if (state == core_pkg::EXECUTE) begin
            result_q <= alu_result;
        end
        if (dmem_done && dec_q.memread) begin
            load_q <= dresp.data;
        end
    end

    assign wd = wb_sel ? load_q : result_q;

    // request fields stay steady for the whole fetch or memory state
    always_comb begin
        ireq.valid  = fetch_req;
        ireq.addr   = pc;
        dreq.valid  = mem_req;
        dreq.addr   = result_q;
        dreq.strobe = dec_q.memwrite ? 4'hf : 4'h0;
        dreq.data   = rd2;
    end

endmodule

//--- tests/core_checker.sv
`timescale 1ns/1ps

module core_checker (
    input  logic                clk,
    input  logic                resetn,
    input  bus_pkg::dbus_req_t  dreq,
    input  bus_pkg::dbus_resp_t dresp,
    output int                  pass_count,
    output int                  fail_count,
    output logic                done
);

    logic [31:0]        exp_addr [$];
    logic [31:0]        exp_data [$];
    int                 total = 0;
    int                 seen;
    logic               waiting;
    bus_pkg::dbus_req_t held;

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        total++;
    endtask

    assign done = (total > 0) && (seen == total);

    always @(posedge clk) begin : watch
        int          fails;
        logic [31:0] want_addr;
        logic [31:0] want_data;
        fails = 0;
        if (resetn) begin
            pass_count <= 0;
            fail_count <= 0;
            seen       <= 0;
            waiting    <= 1'b0;
        end else begin
            // request must not move while ready is held off
            if (waiting && dreq.valid && dreq != held) begin
                $display("data request changed while it was waiting for ready");
                fails++;
            end
            waiting <= dreq.valid && !dresp.ready;
            held    <= dreq;
            if (dreq.valid && dresp.ready && dreq.strobe != 4'h0) begin
                if (exp_addr.size() == 0) begin
                    $display("store to 0x%08h arrived after the last expected store", dreq.addr);
                    fails++;
                end else begin
                    want_addr = exp_addr.pop_front();
                    want_data = exp_data.pop_front();
                    if (dreq.addr !== want_addr) begin
                        $display("FAIL store %0d: dreq.addr expected 0x%08h got 0x%08h",
                                 seen + 1, want_addr, dreq.addr);
                        fails++;
                    end else if (dreq.data !== want_data) begin
                        $display("FAIL store %0d: dreq.data expected 0x%08h got 0x%08h",
                                 seen + 1, want_data, dreq.data);
                        fails++;
                    end else if (dreq.strobe !== 4'hf) begin
                        // a word store writes all four byte lanes
                        $display("FAIL store %0d: dreq.strobe expected 0x%01h got 0x%01h",
                                 seen + 1, 4'hf, dreq.strobe);
                        fails++;
                    end else begin
                        $display("store %0d: 0x%08h at 0x%08h ok", seen + 1, dreq.data, dreq.addr);
                        pass_count <= pass_count + 1;
                    end
                    seen <= seen + 1;
                end
            end
            fail_count <= fail_count + fails;
        end
    end

endmodule

//--- tests/tb_mycore.sv
`timescale 1ns/1ps

module tb_mycore;

    localparam int MEM_WORDS  = 1024;
    localparam int STIM_WORDS = 128;

    logic                clk;
    logic                resetn = 1'b1;
    bus_pkg::ibus_req_t  ireq;
    bus_pkg::ibus_resp_t iresp = '0;
    bus_pkg::dbus_req_t  dreq;
    bus_pkg::dbus_resp_t dresp = '0;

    logic [31:0] mem  [MEM_WORDS];
    logic [31:0] stim [STIM_WORDS];
    integer      seed = 32'h4692_e6de;
    int          cycles = 0;
    int          limit = 0;
    int          prog_len;
    int          store_count;
    int          i_wait;
    int          i_delay;
    int          d_wait;
    int          d_delay;
    int          pass_count;
    int          fail_count;
    logic        done;
    logic        load_ok;
    logic        timed_out;

    mycore dut_i (.clk, .resetn, .ireq, .iresp, .dreq, .dresp);

    core_checker checker_i (.clk, .resetn, .dreq, .dresp, .pass_count, .fail_count, .done);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // 1024 word memory with the upper address bits ignored
    function automatic int word_index(input logic [31:0] addr);
        return int'(addr[11:2]);
    endfunction

    task automatic write_mem(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strobe);
        int idx;
        idx = word_index(addr);
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                mem[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    // ready rises 0 to 3 cycles after valid is seen and drops after the transfer
    always @(posedge clk) begin
        if (resetn) begin
            iresp   <= '0;
            dresp   <= '0;
            i_wait  <= 0;
            i_delay <= 0;
            d_wait  <= 0;
            d_delay <= 0;
        end else begin
            if (iresp.ready) begin
                iresp.ready <= 1'b0;
                i_delay     <= $unsigned($random(seed)) % 4;
            end else if (ireq.valid) begin
                if (i_wait >= i_delay) begin
                    iresp.ready <= 1'b1;
                    iresp.data  <= mem[word_index(ireq.addr)];
                    i_wait      <= 0;
                end else begin
                    i_wait <= i_wait + 1;
                end
            end
            if (dresp.ready) begin
                dresp.ready <= 1'b0;
                d_delay     <= $unsigned($random(seed)) % 4;
                if (dreq.strobe != 4'h0) begin
                    write_mem(dreq.addr, dreq.data, dreq.strobe);
                end
            end else if (dreq.valid) begin
                if (d_wait >= d_delay) begin
                    dresp.ready <= 1'b1;
                    dresp.data  <= mem[word_index(dreq.addr)];
                    d_wait      <= 0;
                end else begin
                    d_wait <= d_wait + 1;
                end
            end
        end
    end

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {~i[15:0], i[15:0]};
        end
        $readmemh("tests/mem_stimulus.hex", stim);
        load_ok = !$isunknown(stim[0]);
        if (load_ok) begin
            prog_len = stim[0];
            for (int i = 0; i < prog_len; i++) begin
                mem[word_index(core_pkg::RESET_PC + 4 * i)] = stim[1 + i];
            end
            store_count = stim[prog_len + 1];
            for (int k = 0; k < store_count; k++) begin
                checker_i.expect_store(stim[prog_len + 2 + 2 * k], stim[prog_len + 3 + 2 * k]);
            end
            // worst case of five states at up to four cycles each
            limit = prog_len * 5 * 4 + 100;
        end else begin
            $display("stimulus file tests/mem_stimulus.hex could not be read");
        end

        repeat (2) @(posedge clk);
        resetn <= 1'b0;

        while (load_ok && !done && cycles < limit) begin
            @(posedge clk);
        end
        timed_out = load_ok && !done;
        // a stray store after the last expected one still gets caught
        if (load_ok && !timed_out) begin
            repeat (20) @(posedge clk);
        end
        if (timed_out) begin
            $display("timeout after %0d cycles, the core stopped before all expected stores arrived",
                     cycles);
        end
        $display("stores checked: %0d passed, %0d failed", pass_count, fail_count);
        if (load_ok && !timed_out && fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/mem_stimulus.hex
// word 0 is the program length, then the program words placed at the reset pc
// then the number of expected stores, then one store address and data pair per line
00000020
3c011234 24215678 2402fffd 00221821 // lui, addiu, addiu -3, addu
00222023 00232824 00233025 0041382a // subu, and, or, slt negative operand
0022402a ac010100 ac020104 ac030108 // slt, stores
ac04010c ac050110 ac060114 ac070118
ac08011c 3c09beef ac090120 8c0a0100 // lui upper half, load back
ac0a0124 24000055 ac000128 102a0001 // store loaded word, write r0, store r0, beq taken
ac0101f0 10220001 ac02012c 14220001 // skipped store, beq not taken, store, bne taken
ac0101f4 142a0001 ac030130 1000ffff // skipped store, bne not taken, store, self loop
0000000d
00000100 12345678
00000104 fffffffd
00000108 12345675
0000010c 1234567b
00000110 12345670
00000114 1234567d
00000118 00000001
0000011c 00000000
00000120 beef0000
00000124 12345678
00000128 00000000
0000012c fffffffd
00000130 12345675

//--- verilog.f
src/bus_pkg.sv
src/core_pkg.sv
src/core_ctrl.sv
src/pc_unit.sv
src/decoder.sv
src/alu.sv
src/regfile.sv
src/mycore.sv
tests/core_checker.sv
tests/tb_mycore.sv

//--- Bender.yml
package:
  name: mycore

sources:
  - files:
      - src/bus_pkg.sv
      - src/core_pkg.sv
      - src/core_ctrl.sv
      - src/pc_unit.sv
      - src/decoder.sv
      - src/alu.sv
      - src/regfile.sv
      - src/mycore.sv
  - target: test
    files:
      - tests/core_checker.sv
      - tests/tb_mycore.sv
